/* eth_pkg.sv */
package eth_pkg;

    // ============================================================
    // gmii framing
    // ============================================================

    // seven of these ahead of the SFD
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam int         PREAMBLE_LEN  = 7;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // frame sizes after the SFD, FCS included
    localparam int MIN_FRAME_BYTES = 64;
    localparam int MAX_FRAME_BYTES = 1518;
    localparam int LEN_W           = $clog2(MAX_FRAME_BYTES + 1);

    // dst + src + ethertype
    localparam int HEADER_BYTES   = 14;
    localparam int MAC_ADDR_BYTES = 6;

    // ============================================================
    // crc-32
    // ============================================================

    localparam logic [31:0] CRC32_POLY_REFLECTED = 32'hEDB88320;
    localparam logic [31:0] CRC32_INIT           = 32'hFFFFFFFF;
    // register value once the FCS itself has been folded in
    localparam logic [31:0] CRC32_RESIDUE        = 32'hDEBB20E3;

    localparam int IFG_BYTES = 12;

endpackage

/* rx_pkg.sv */
package rx_pkg;

    // bytes per output block
    localparam int BLOCK_BYTES = 8;

    // counter widths
    localparam int LANE_W    = $clog2(BLOCK_BYTES);
    localparam int HDR_CNT_W = $clog2(eth_pkg::HEADER_BYTES + 1);
    localparam int PRE_CNT_W = $clog2(eth_pkg::PREAMBLE_LEN + 1);
    localparam int IFG_CNT_W = $clog2(eth_pkg::IFG_BYTES);

    // one frame byte, sof marks the byte right after the SFD
    typedef struct packed {
        logic       valid;
        logic       sof;
        logic [7:0] data;
    } rx_byte_t;

    // single-cycle end of frame marker
    typedef struct packed {
        logic                      valid;
        logic                      error;
        logic                      crc_error;
        logic [eth_pkg::LEN_W-1:0] length;
    } frame_end_t;

    // addresses in wire order, first byte in the top index
    typedef struct packed {
        logic [eth_pkg::MAC_ADDR_BYTES-1:0][7:0] dst_addr;
        logic [eth_pkg::MAC_ADDR_BYTES-1:0][7:0] src_addr;
        logic [15:0]                             eth_type;
    } mac_hdr_t;

    typedef struct packed {
        logic [BLOCK_BYTES-1:0][7:0] data;
        logic                        valid;
        logic                        eof;
        logic                        error;
        logic [eth_pkg::LEN_W-1:0]   length;
    } frame_block_t;

    typedef struct packed {
        logic [31:0] rx_frame_count;
        logic [31:0] rx_error_count;
        logic [31:0] crc_error_count;
        logic [31:0] preamble_error_count;
    } rx_stats_t;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        FRAME,
        DRAIN,
        WAIT_IFG
    } rx_state_t;

endpackage

/* crc32_gen.sv */
`timescale 1ns/1ps

module crc32_gen (
    input  logic        clk,
    input  logic        sync_switch_rst_n,
    input  logic        init,
    input  logic        enable,
    input  logic [7:0]  data,
    output logic [31:0] crc
);
    import eth_pkg::*;

    // one byte through the reflected register, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'h0, d};
        // unrolls to eight shift/xor steps
        for (int i = 0; i < 8; i++) begin
            if (r[0]) begin
                r = (r >> 1) ^ CRC32_POLY_REFLECTED;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            crc <= CRC32_INIT;
        end else if (init) begin
            // reseed on every SFD
            crc <= CRC32_INIT;
        end else if (enable) begin
            crc <= crc_byte(crc, data);
        end
    end

endmodule

/* rx_frame_fsm.sv */
`timescale 1ns/1ps

module rx_frame_fsm (
    input  logic               clk,
    input  logic               sync_switch_rst_n,
    input  logic [7:0]         gmii_rx_data,
    input  logic               gmii_rx_dv,
    input  logic               gmii_rx_er,
    output rx_pkg::rx_byte_t   rx_byte,
    output rx_pkg::frame_end_t frame_end,
    output logic               preamble_error
);
    import eth_pkg::*;
    import rx_pkg::*;

    rx_state_t             state;
    logic [PRE_CNT_W-1:0]  pre_cnt;
    logic [LEN_W-1:0]      byte_cnt;
    logic [IFG_CNT_W-1:0]  ifg_cnt;
    // er seen or bytes past the size limit
    logic                  err_sticky;
    logic                  first_byte;
    logic [31:0]           crc;
    logic                  sfd_hit;
    logic                  take_byte;
    logic                  frame_done;
    logic                  crc_bad;

    // seventh preamble byte already counted, this one is the SFD
    assign sfd_hit = (state == PREAMBLE) && gmii_rx_dv && !gmii_rx_er &&
                     (pre_cnt == PRE_CNT_W'(PREAMBLE_LEN)) && (gmii_rx_data == SFD_BYTE);
    assign take_byte  = (state == FRAME) && gmii_rx_dv && !gmii_rx_er;
    // first dv-low cycle after the SFD
    assign frame_done = ((state == FRAME) || (state == DRAIN)) && !gmii_rx_dv;
    assign crc_bad    = (crc != CRC32_RESIDUE);

    crc32_gen u_crc (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .init              (sfd_hit),
        .enable            (take_byte),
        .data              (gmii_rx_data),
        .crc               (crc)
    );

    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            state          <= IDLE;
            pre_cnt        <= '0;
            byte_cnt       <= '0;
            ifg_cnt        <= '0;
            err_sticky     <= 1'b0;
            first_byte     <= 1'b0;
            rx_byte        <= '0;
            frame_end      <= '0;
            preamble_error <= 1'b0;
        end else begin
            // stream is one cycle behind gmii
            rx_byte.valid <= take_byte;
            rx_byte.sof   <= take_byte && first_byte;
            rx_byte.data  <= gmii_rx_data;

            // crc already holds the last byte on the frame_done cycle
            frame_end.valid     <= frame_done;
            frame_end.error     <= frame_done && (err_sticky || crc_bad ||
                                   (byte_cnt < LEN_W'(MIN_FRAME_BYTES)));
            frame_end.crc_error <= frame_done && crc_bad && !err_sticky;
            frame_end.length    <= byte_cnt;

            preamble_error <= (state == PREAMBLE) && gmii_rx_er;

            case (state)
                IDLE: begin
                    if (gmii_rx_dv && !gmii_rx_er && gmii_rx_data == PREAMBLE_BYTE) begin
                        pre_cnt <= PRE_CNT_W'(1);
                        state   <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    if (sfd_hit) begin
                        byte_cnt   <= '0;
                        err_sticky <= 1'b0;
                        first_byte <= 1'b1;
                        state      <= FRAME;
                    end else if (!gmii_rx_dv || gmii_rx_er) begin
                        state <= IDLE;
                    end else if (pre_cnt == PRE_CNT_W'(PREAMBLE_LEN) ||
                                 gmii_rx_data != PREAMBLE_BYTE) begin
                        // bad sfd or bad preamble byte, dropped quietly
                        state <= IDLE;
                    end else begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end
                FRAME: begin
                    if (frame_done) begin
                        ifg_cnt <= '0;
                        state   <= WAIT_IFG;
                    end else if (gmii_rx_er) begin
                        err_sticky <= 1'b1;
                        state      <= DRAIN;
                    end else begin
                        byte_cnt   <= byte_cnt + 1'b1;
                        first_byte <= 1'b0;
                        // stop forwarding at max size
                        if (byte_cnt == LEN_W'(MAX_FRAME_BYTES - 1)) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    if (frame_done) begin
                        ifg_cnt <= '0;
                        state   <= WAIT_IFG;
                    end else begin
                        // any byte here means oversize
                        err_sticky <= 1'b1;
                    end
                end
                WAIT_IFG: begin
                    if (ifg_cnt == IFG_CNT_W'(IFG_BYTES - 1)) begin
                        state <= IDLE;
                    end else begin
                        ifg_cnt <= ifg_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_end_not_byte: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_end.valid |-> !rx_byte.valid);

    a_len_max: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_end.valid |-> frame_end.length <= LEN_W'(MAX_FRAME_BYTES));

endmodule

/* header_extractor.sv */
`timescale 1ns/1ps

module header_extractor (
    input  logic             clk,
    input  logic             sync_switch_rst_n,
    input  rx_pkg::rx_byte_t rx_byte,
    output rx_pkg::mac_hdr_t mac_hdr,
    output logic             dst_valid,
    output logic             src_valid,
    output logic             type_valid
);
    import eth_pkg::*;
    import rx_pkg::*;

    // parked at HEADER_BYTES between frames
    logic [HDR_CNT_W-1:0] hdr_cnt;
    logic [HDR_CNT_W-1:0] idx;
    logic                 take;

    assign idx  = rx_byte.sof ? '0 : hdr_cnt;
    assign take = rx_byte.valid && (idx < HDR_CNT_W'(HEADER_BYTES));

    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            hdr_cnt    <= HDR_CNT_W'(HEADER_BYTES);
            dst_valid  <= 1'b0;
            src_valid  <= 1'b0;
            type_valid <= 1'b0;
        end else begin
            if (take) begin
                hdr_cnt <= idx + 1'b1;
            end
            // pulse on the last byte of each field
            dst_valid  <= take && (idx == HDR_CNT_W'(MAC_ADDR_BYTES - 1));
            src_valid  <= take && (idx == HDR_CNT_W'(2 * MAC_ADDR_BYTES - 1));
            type_valid <= take && (idx == HDR_CNT_W'(HEADER_BYTES - 1));
        end
    end

    // field shift registers
    always_ff @(posedge clk) begin
        if (take) begin
            if (idx < HDR_CNT_W'(MAC_ADDR_BYTES)) begin
                mac_hdr.dst_addr <= {mac_hdr.dst_addr[MAC_ADDR_BYTES-2:0], rx_byte.data};
            end else if (idx < HDR_CNT_W'(2 * MAC_ADDR_BYTES)) begin
                mac_hdr.src_addr <= {mac_hdr.src_addr[MAC_ADDR_BYTES-2:0], rx_byte.data};
            end else begin
                mac_hdr.eth_type <= {mac_hdr.eth_type[7:0], rx_byte.data};
            end
        end
    end

    a_one_valid: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        $onehot0({dst_valid, src_valid, type_valid}));

endmodule

/* block_packer.sv */
`timescale 1ns/1ps

module block_packer (
    input  logic                 clk,
    input  logic                 sync_switch_rst_n,
    input  rx_pkg::rx_byte_t     rx_byte,
    input  rx_pkg::frame_end_t   frame_end,
    output rx_pkg::frame_block_t frame_block
);
    import rx_pkg::*;

    // bytes held in the current block
    logic [LANE_W-1:0]           lane_cnt;
    logic [LANE_W-1:0]           lane_idx;
    logic [BLOCK_BYTES-1:0][7:0] blk_buf;
    logic [BLOCK_BYTES-1:0][7:0] blk_next;
    logic [BLOCK_BYTES-1:0][7:0] blk_padded;

    // sof forces a fresh block
    assign lane_idx = rx_byte.sof ? '0 : lane_cnt;
    // newest byte enters lane 0, oldest climbs toward the top lane
    assign blk_next = {blk_buf[BLOCK_BYTES-2:0], rx_byte.data};
    // move a partial block to the top lanes, zeros below
    assign blk_padded = blk_buf << (8 * (BLOCK_BYTES - int'(lane_cnt)));

    always_ff @(posedge clk) begin
        if (rx_byte.valid) begin
            blk_buf <= blk_next;
        end
    end

    // ============================================================
    // block output
    // ============================================================

    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            lane_cnt    <= '0;
            frame_block <= '0;
        end else begin
            frame_block.valid <= 1'b0;
            frame_block.eof   <= 1'b0;
            if (rx_byte.valid) begin
                // wraps to zero after the last lane
                lane_cnt <= lane_idx + 1'b1;
                if (lane_idx == LANE_W'(BLOCK_BYTES - 1)) begin
                    frame_block.valid <= 1'b1;
                    frame_block.data  <= blk_next;
                end
            end else if (frame_end.valid) begin
                lane_cnt <= '0;
                // valid only when a partial block is pending
                frame_block.valid  <= (lane_cnt != '0);
                frame_block.eof    <= 1'b1;
                frame_block.data   <= blk_padded;
                frame_block.error  <= frame_end.error;
                frame_block.length <= frame_end.length;
            end
        end
    end

    a_eof_len: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof && !frame_block.error |-> frame_block.length != '0);

endmodule

/* rx_stats.sv */
`timescale 1ns/1ps

module rx_stats (
    input  logic               clk,
    input  logic               sync_switch_rst_n,
    input  rx_pkg::frame_end_t frame_end,
    input  logic               preamble_error,
    output rx_pkg::rx_stats_t  stats
);
    import rx_pkg::*;

    // free-running, wrap at 2^32
    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            stats <= '0;
        end else begin
            if (frame_end.valid) begin
                // every frame end counts, good or bad
                stats.rx_frame_count <= stats.rx_frame_count + 32'd1;
                if (frame_end.error) begin
                    stats.rx_error_count <= stats.rx_error_count + 32'd1;
                end
                if (frame_end.crc_error) begin
                    stats.crc_error_count <= stats.crc_error_count + 32'd1;
                end
            end
            // no frame end for these
            if (preamble_error) begin
                stats.preamble_error_count <= stats.preamble_error_count + 32'd1;
            end
        end
    end

endmodule

/* rx_mac_control.sv */
`timescale 1ns/1ps

module rx_mac_control (
    input  logic                 clk,
    input  logic                 sync_switch_rst_n,
    input  logic [7:0]           gmii_rx_data,
    input  logic                 gmii_rx_dv,
    input  logic                 gmii_rx_er,
    output rx_pkg::mac_hdr_t     mac_hdr,
    output logic                 dst_valid,
    output logic                 src_valid,
    output logic                 type_valid,
    output rx_pkg::frame_block_t frame_block,
    output rx_pkg::rx_stats_t    stats
);
    import rx_pkg::*;

    // fsm to header, packer and stats
    rx_byte_t   rx_byte;
    frame_end_t frame_end;
    logic       preamble_error;

    rx_frame_fsm u_fsm (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .gmii_rx_data      (gmii_rx_data),
        .gmii_rx_dv        (gmii_rx_dv),
        .gmii_rx_er        (gmii_rx_er),
        .rx_byte           (rx_byte),
        .frame_end         (frame_end),
        .preamble_error    (preamble_error)
    );

    header_extractor u_hdr (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .rx_byte           (rx_byte),
        .mac_hdr           (mac_hdr),
        .dst_valid         (dst_valid),
        .src_valid         (src_valid),
        .type_valid        (type_valid)
    );

    block_packer u_pack (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .rx_byte           (rx_byte),
        .frame_end         (frame_end),
        .frame_block       (frame_block)
    );

    rx_stats u_stats (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .frame_end         (frame_end),
        .preamble_error    (preamble_error),
        .stats             (stats)
    );

endmodule

/* tb_rx_mac_control.sv */
`timescale 1ns/1ps

module tb_rx_mac_control;
    import eth_pkg::*;
    import rx_pkg::*;

    logic                        clk;
    logic                        sync_switch_rst_n;
    logic [7:0]                  gmii_rx_data;
    logic                        gmii_rx_dv;
    logic                        gmii_rx_er;
    mac_hdr_t                    mac_hdr;
    logic                        dst_valid;
    logic                        src_valid;
    logic                        type_valid;
    frame_block_t                frame_block;
    rx_stats_t                   stats;

    // reference model state, moved only on the falling edge
    logic [7:0]                  exp_bytes[$];
    logic [BLOCK_BYTES-1:0][7:0] exp_block;
    int                          exp_left;
    logic                        blk_taken;
    logic [47:0]                 exp_dst;
    logic [47:0]                 exp_src;
    logic [15:0]                 exp_type;
    logic                        exp_error;
    logic [LEN_W-1:0]            exp_len;
    rx_stats_t                   exp_stats;
    logic                        eof_expected;
    // header valids seen in the current frame
    int                          dst_pulses;
    int                          src_pulses;
    int                          type_pulses;
    int                          mismatches;
    int                          timeouts;

    rx_mac_control u_dut (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .gmii_rx_data      (gmii_rx_data),
        .gmii_rx_dv        (gmii_rx_dv),
        .gmii_rx_er        (gmii_rx_er),
        .mac_hdr           (mac_hdr),
        .dst_valid         (dst_valid),
        .src_valid         (src_valid),
        .type_valid        (type_valid),
        .frame_block       (frame_block),
        .stats             (stats)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        mismatches++;
        $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    // ============================================================
    // expected block from the head of the byte queue
    // ============================================================

    always @(negedge clk) begin
        int n;
        // drop the block that the last rising edge checked
        if (blk_taken) begin
            n = (exp_bytes.size() < BLOCK_BYTES) ? exp_bytes.size() : BLOCK_BYTES;
            repeat (n) begin
                void'(exp_bytes.pop_front());
            end
        end
        blk_taken = frame_block.valid;
        exp_left  = exp_bytes.size();
        // first byte in the top lane, zeros past the queue end
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            exp_block[BLOCK_BYTES-1-i] = (i < exp_left) ? exp_bytes[i] : 8'h00;
        end
    end

    // one-cycle pulses, so each falling edge sees a pulse once
    always @(negedge clk) begin
        if (dst_valid) begin
            dst_pulses++;
        end
        if (src_valid) begin
            src_pulses++;
        end
        if (type_valid) begin
            type_pulses++;
        end
    end

    // ============================================================
    // checkers
    // ============================================================

    a_dst: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        dst_valid |-> mac_hdr.dst_addr == exp_dst)
        else report_mismatch("mac_hdr.dst_addr", $sampled(mac_hdr.dst_addr), exp_dst);
    a_src: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        src_valid |-> mac_hdr.src_addr == exp_src)
        else report_mismatch("mac_hdr.src_addr", $sampled(mac_hdr.src_addr), exp_src);
    a_type: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        type_valid |-> mac_hdr.eth_type == exp_type)
        else report_mismatch("mac_hdr.eth_type", $sampled(mac_hdr.eth_type), exp_type);
    // each header field announced exactly once per frame
    a_dst_once: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof |-> dst_pulses == 1)
        else report_mismatch("dst_valid pulses", $sampled(dst_pulses), 1);
    a_src_once: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof |-> src_pulses == 1)
        else report_mismatch("src_valid pulses", $sampled(src_pulses), 1);
    a_type_once: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof |-> type_pulses == 1)
        else report_mismatch("type_valid pulses", $sampled(type_pulses), 1);
    a_data: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.valid |-> frame_block.data == exp_block)
        else report_mismatch("frame_block.data", $sampled(frame_block.data), exp_block);
    // partial block pending exactly when bytes are left over
    a_last: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof |-> frame_block.valid == (exp_left != 0))
        else report_mismatch("frame_block.valid", $sampled(frame_block.valid), exp_left != 0);
    a_error: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof |-> frame_block.error == exp_error)
        else report_mismatch("frame_block.error", $sampled(frame_block.error), exp_error);
    a_length: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof |-> frame_block.length == exp_len)
        else report_mismatch("frame_block.length", $sampled(frame_block.length), exp_len);
    // counters settle on the same edge as eof
    a_stats: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof |-> stats == exp_stats)
        else report_mismatch("stats", $sampled(stats), exp_stats);
    a_no_stray: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_block.eof |-> eof_expected)
        else begin
            mismatches++;
            $display("at %0t: end of frame marker seen with no frame in flight", $time);
        end

    // ============================================================
    // frame generator
    // ============================================================

    // bitwise reflected crc, lsb of each byte first
    function automatic logic [31:0] crc_of(input logic [7:0] bytes[$]);
        logic [31:0] c;
        logic        fb;
        c = CRC32_INIT;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ bytes[i][b];
                c  = {1'b0, c[31:1]} ^ (fb ? CRC32_POLY_REFLECTED : 32'h0);
            end
        end
        return c;
    endfunction

    task automatic drive_byte(input logic [7:0] d, input logic er);
        @(negedge clk);
        gmii_rx_data = d;
        gmii_rx_dv   = 1'b1;
        gmii_rx_er   = er;
    endtask

    task automatic drive_idle();
        gmii_rx_data = 8'h00;
        gmii_rx_dv   = 1'b0;
        gmii_rx_er   = 1'b0;
    endtask

    task automatic wait_frame_end();
        int cycles;
        cycles = 0;
        while (!frame_block.eof && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (!frame_block.eof) begin
            timeouts++;
            $display("at %0t: timed out waiting for the end of frame marker", $time);
        end
        @(negedge clk);
        eof_expected = 1'b0;
    endtask

    // er_at below zero means no er inside the frame
    task automatic send_frame(input int len, input int er_at, input logic bad_fcs);
        logic [7:0]  f[$];
        logic [31:0] fcs;
        int          fwd;
        for (int i = 0; i < len - 4; i++) begin
            f.push_back(8'($urandom));
        end
        // fcs goes out low byte first
        fcs = ~crc_of(f);
        for (int i = 0; i < 4; i++) begin
            f.push_back(fcs[8*i +: 8]);
        end
        if (bad_fcs) begin
            f[len-2] = f[len-2] ^ 8'h5A;
        end
        // bytes the mac forwards before er or the size cut
        fwd = (er_at >= 0) ? er_at : ((len > MAX_FRAME_BYTES) ? MAX_FRAME_BYTES : len);
        for (int i = 0; i < fwd; i++) begin
            exp_bytes.push_back(f[i]);
        end
        for (int i = 0; i < MAC_ADDR_BYTES; i++) begin
            exp_dst = {exp_dst[39:0], f[i]};
            exp_src = {exp_src[39:0], f[MAC_ADDR_BYTES+i]};
        end
        exp_type  = {f[12], f[13]};
        exp_len   = LEN_W'(fwd);
        exp_error = (er_at >= 0) || (len < MIN_FRAME_BYTES) ||
                    (len > MAX_FRAME_BYTES) || bad_fcs;
        exp_stats.rx_frame_count = exp_stats.rx_frame_count + 1;
        if (exp_error) begin
            exp_stats.rx_error_count = exp_stats.rx_error_count + 1;
        end
        // crc fault only counts when nothing else went wrong first
        if (bad_fcs && er_at < 0 && len <= MAX_FRAME_BYTES) begin
            exp_stats.crc_error_count = exp_stats.crc_error_count + 1;
        end
        dst_pulses   = 0;
        src_pulses   = 0;
        type_pulses  = 0;
        eof_expected = 1'b1;
        repeat (PREAMBLE_LEN) begin
            drive_byte(PREAMBLE_BYTE, 1'b0);
        end
        drive_byte(SFD_BYTE, 1'b0);
        for (int i = 0; i < len; i++) begin
            drive_byte(f[i], i == er_at);
        end
        @(negedge clk);
        drive_idle();
        wait_frame_end();
        repeat (16) @(negedge clk);
    endtask

    // er inside the preamble, no frame should come of it
    task automatic abort_preamble();
        exp_stats.preamble_error_count = exp_stats.preamble_error_count + 1;
        repeat (3) begin
            drive_byte(PREAMBLE_BYTE, 1'b0);
        end
        drive_byte(PREAMBLE_BYTE, 1'b1);
        @(negedge clk);
        drive_idle();
        repeat (16) @(negedge clk);
    endtask

    initial begin
        int seed_sink;
        seed_sink         = $urandom(20701);
        sync_switch_rst_n = 1'b0;
        drive_idle();
        mismatches   = 0;
        timeouts     = 0;
        exp_stats    = '0;
        eof_expected = 1'b0;
        blk_taken    = 1'b0;
        exp_dst      = '0;
        exp_src      = '0;
        exp_type     = '0;
        dst_pulses   = 0;
        src_pulses   = 0;
        type_pulses  = 0;
        repeat (3) @(negedge clk);
        sync_switch_rst_n = 1'b1;
        repeat (4) @(negedge clk);

        // clean frames, 64 is a whole number of blocks
        send_frame(64, -1, 1'b0);
        repeat (3) begin
            send_frame($urandom_range(200, 65), -1, 1'b0);
        end
        send_frame(96, -1, 1'b1);
        // runt with a good fcs
        send_frame(40, -1, 1'b0);
        abort_preamble();
        send_frame(100, 30, 1'b0);
        send_frame(1530, -1, 1'b0);
        send_frame(72, -1, 1'b0);

        $display("summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* files.f */
eth_pkg.sv
rx_pkg.sv
crc32_gen.sv
rx_frame_fsm.sv
header_extractor.sv
block_packer.sv
rx_stats.sv
rx_mac_control.sv
tb_rx_mac_control.sv

/* run.sh */
#!/bin/sh
# build and run the rx mac testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_rx_mac_control -o sim_rx_mac
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_rx_mac)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -qx "NO ERRORS" || exit 1
exit 0
